//--- design/pad_cfg.svh
/*
 * game-pad timing and width settings
 * NES poll timing assumes a 64 MHz system clock
 */
`ifndef PAD_CFG_SVH
`define PAD_CFG_SVH

// NES poll timing, sized for the 11-bit cycle counter
`define PAD_NES_LATCH_CYCLES 11'd768   // 12 us latch pulse and one bit slot
`define PAD_NES_HALF_CYCLES  11'd384   // 6 us, high half of a slot

// NES pad
`define PAD_NES_BUTTONS 8              // A B select start up down left right

// SNES frame from the PMOD adapter
`define PAD_SNES_BITS 12               // b y sel start u d l r a x l r

// plausibility limit, more pressed than this is treated as a glitch
`define PAD_MAX_PRESSED 2

`endif

//--- design/pad_pkg.sv
/*
 * game-pad shared types
 * poller states, NES button byte and SNES frame word
 */
`include "pad_cfg.svh"

package pad_pkg;

    // NES poller states
    typedef enum logic [1:0] {
        LATCH = 2'd0,   // latch pulse high
        FIRST = 2'd1,   // A already on the line, short wait
        SLOT  = 2'd2    // one clock pulse per remaining bit
    } nes_state_t;

    // NES buttons, active high
    // bit 7 A, 6 B, 5 select, 4 start, 3 up, 2 down, 1 left, 0 right
    typedef logic [`PAD_NES_BUTTONS-1:0] nes_byte_t;

    // SNES frame in arrival order, b first
    // bit 11 b, 10 y, 9 select, 8 start, 7 up, 6 down, 5 left, 4 right,
    // bit 3 a, 2 x, 1 l, 0 r
    // all ones means no pad behind the adapter
    typedef logic [`PAD_SNES_BITS-1:0] snes_frame_t;

endpackage

//--- design/nes_poller.sv
/*
 * NES controller poller
 * drives latch and clock of a classic NES pad, shifts in the eight
 * buttons and publishes the whole byte once per poll
 */
`include "pad_cfg.svh"

module nes_poller
    import pad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      nes_data,    // low while a button is pressed
    output logic      nes_latch,
    output logic      nes_clk,
    output nes_byte_t buttons      // active high, released after reset
);

    // index of the last clocked slot, A comes without a clock pulse
    localparam logic [2:0] LAST_SLOT = 3'(`PAD_NES_BUTTONS - 2);

    nes_state_t state;
    logic [10:0] count;           // cycles within the current state
    logic [2:0]  slot;            // clocked bit slot, B up to right
    nes_byte_t   shift_reg;       // raw line levels, A ends up in the msb
    logic        sample;
    logic        publish;

    // A is valid right after the latch, later bits mid-slot after the clock edge
    assign sample = ((state == FIRST) && (count == '0)) ||
                    ((state == SLOT) && (count == `PAD_NES_HALF_CYCLES));

    // end of the seventh slot, shift register holds all eight bits
    assign publish = (state == SLOT) && (slot == LAST_SLOT) &&
                     (count == `PAD_NES_LATCH_CYCLES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= LATCH;
            count     <= '0;
            slot      <= '0;
            nes_latch <= 1'b0;
            nes_clk   <= 1'b0;
            buttons   <= '0;
        end else begin
            // pins follow the state one cycle late
            nes_latch <= (state == LATCH);
            nes_clk   <= (state == SLOT) && (count <= `PAD_NES_HALF_CYCLES);

            if (publish) begin
                buttons <= ~shift_reg;   // line is low for pressed
            end

            case (state)
                LATCH: begin
                    if (count == `PAD_NES_LATCH_CYCLES) begin
                        count <= '0;
                        state <= FIRST;
                    end else begin
                        count <= count + 11'd1;
                    end
                end
                FIRST: begin
                    // half slot before the first clock pulse
                    if (count == `PAD_NES_HALF_CYCLES) begin
                        count <= '0;
                        slot  <= '0;
                        state <= SLOT;
                    end else begin
                        count <= count + 11'd1;
                    end
                end
                SLOT: begin
                    if (count == `PAD_NES_LATCH_CYCLES) begin
                        count <= '0;
                        if (slot == LAST_SLOT) begin
                            slot  <= '0;
                            state <= LATCH;   // next poll starts right away
                        end else begin
                            slot <= slot + 3'd1;
                        end
                    end else begin
                        count <= count + 11'd1;
                    end
                end
                default: begin
                    count <= '0;
                    slot  <= '0;
                    state <= LATCH;
                end
            endcase
        end
    end

    // sampled bits, msb first
    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg <= {shift_reg[`PAD_NES_BUTTONS-2:0], nes_data};
        end
    end

endmodule

//--- design/snes_pmod_capture.sv
/*
 * SNES PMOD capture
 * samples the adapter's serial stream on its own clock and latch
 * and holds the last complete frame
 */
`include "pad_cfg.svh"

module snes_pmod_capture
    import pad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pmod_data,
    input  logic        pmod_clk,
    input  logic        pmod_latch,
    output snes_frame_t frame        // all ones until a pad is seen
);

    // two-flop synchronizers, index 1 is the usable stage
    logic [1:0]  data_sync;
    logic [1:0]  clk_sync;
    logic [1:0]  latch_sync;
    logic        clk_prev;
    logic        latch_prev;
    logic        clk_rise;
    logic        latch_rise;
    snes_frame_t shift_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sync  <= '0;
            clk_sync   <= '0;
            latch_sync <= '0;
        end else begin
            data_sync  <= {data_sync[0], pmod_data};
            clk_sync   <= {clk_sync[0], pmod_clk};
            latch_sync <= {latch_sync[0], pmod_latch};
        end
    end

    assign clk_rise   = clk_sync[1] & ~clk_prev;
    assign latch_rise = latch_sync[1] & ~latch_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
            shift_reg  <= '1;   // reads as no pad
            frame      <= '1;
        end else begin
            clk_prev   <= clk_sync[1];
            latch_prev <= latch_sync[1];
            if (clk_rise) begin
                shift_reg <= {shift_reg[`PAD_SNES_BITS-2:0], data_sync[1]};  // msb first
            end
            if (latch_rise) begin
                frame <= shift_reg;   // whole frame at once
            end
        end
    end

endmodule

//--- design/snes_frame_decoder.sv
/*
 * SNES frame decoder
 * presence check and pressed-button plausibility filter
 */
`include "pad_cfg.svh"

module snes_frame_decoder
    import pad_pkg::*;
(
    input  snes_frame_t frame,
    output snes_frame_t buttons,   // 1 = pressed, 0 when absent or filtered
    output logic        present
);

    // wide enough to count every bit of the frame
    localparam int CNT_W = $clog2(`PAD_SNES_BITS + 1);

    logic [CNT_W-1:0] ones;
    logic             too_many;

    // population count of the frame
    always_comb begin
        ones = '0;
        for (int i = 0; i < `PAD_SNES_BITS; i++) begin
            ones = ones + CNT_W'(frame[i]);
        end
    end

    // adapter reports all ones with nothing plugged in
    assign present = (frame != '1);

    // the adapter sometimes hands over garbage frames,
    // a real player rarely holds more than a couple of buttons
    assign too_many = (ones > CNT_W'(`PAD_MAX_PRESSED));

    assign buttons = (present && !too_many) ? frame : '0;

endmodule

//--- design/pad_top.sv
/*
 * game-pad input block
 * NES poller and SNES PMOD receiver side by side, SNES buttons win
 * whenever an SNES pad is present
 */
module pad_top
    import pad_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic nes_data,
    input  logic pmod_data,
    input  logic pmod_clk,
    input  logic pmod_latch,
    output logic nes_latch,
    output logic nes_clk,
    output logic a,
    output logic b,
    output logic select,
    output logic start,
    output logic up,
    output logic down,
    output logic left,
    output logic right,
    output logic x,
    output logic y,
    output logic l,
    output logic r,
    output logic snes_active     // 1 = SNES source, 0 = NES source
);

    nes_byte_t   nes_buttons;
    snes_frame_t frame;
    snes_frame_t snes_buttons;
    nes_byte_t   snes_common;    // SNES buttons rearranged into NES order
    nes_byte_t   common;
    logic        present;

    nes_poller nes_poller_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .nes_data  (nes_data),
        .nes_latch (nes_latch),
        .nes_clk   (nes_clk),
        .buttons   (nes_buttons)
    );

    snes_pmod_capture snes_pmod_capture_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .frame      (frame)
    );

    snes_frame_decoder snes_frame_decoder_i (
        .frame   (frame),
        .buttons (snes_buttons),
        .present (present)
    );

    // a, b, select, start, then the four directions
    assign snes_common = {snes_buttons[3], snes_buttons[11], snes_buttons[9:4]};

    // priority select
    assign common      = present ? snes_common : nes_buttons;
    assign snes_active = present;

    assign {a, b, select, start, up, down, left, right} = common;

    // SNES-only buttons, held low on the NES path
    assign x = present & snes_buttons[2];
    assign y = present & snes_buttons[10];
    assign l = present & snes_buttons[1];
    assign r = present & snes_buttons[0];

endmodule

//--- tb/pad_models.sv
/*
 * game-pad models for the testbench
 * NES controller shift register and SNES PMOD adapter stream source
 */
`include "pad_cfg.svh"

module nes_pad_model
    import pad_pkg::*;
(
    input  logic      nes_latch,
    input  logic      nes_clk,
    input  nes_byte_t pad_byte,    // active high, A in the msb
    output logic      nes_data     // low while pressed
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] idx = 3'd0;        // button on the line, 0 is A

    // latch restarts at A, each clock rise moves one button on
    always @(posedge nes_clk or posedge nes_latch) begin
        if (nes_latch) begin
            idx <= 3'd0;
        end else begin
            idx <= idx + 3'd1;
        end
    end

    // parallel load while latched, pad follows pad_byte during the pulse
    assign nes_data = nes_latch ? ~pad_byte[7] : ~pad_byte[3'd7 - idx];

endmodule

module snes_pmod_source
    import pad_pkg::*;
(
    input  logic        clk,
    input  logic        send,        // held high until busy rises
    input  snes_frame_t word,        // b first on the wire
    output logic        busy,
    output logic        pmod_data,
    output logic        pmod_clk,
    output logic        pmod_latch
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PHASE = 6;        // cycles per clock half and per latch pulse

    initial begin
        // idle lines, clock parked high, data high
        busy       = 1'b0;
        pmod_data  = 1'b1;
        pmod_clk   = 1'b1;
        pmod_latch = 1'b0;
        forever begin
            @(posedge clk);
            if (send) begin
                busy <= 1'b1;
                for (int i = `PAD_SNES_BITS - 1; i >= 0; i--) begin
                    pmod_clk  <= 1'b0;
                    pmod_data <= word[i];    // settles during the low half
                    repeat (PHASE) @(posedge clk);
                    pmod_clk  <= 1'b1;       // capture shifts on this rise
                    repeat (PHASE) @(posedge clk);
                end
                pmod_latch <= 1'b1;          // frame handed over on the rise
                repeat (PHASE) @(posedge clk);
                pmod_latch <= 1'b0;
                pmod_data  <= 1'b1;
                busy       <= 1'b0;
            end
        end
    end

endmodule

//--- tb/pad_tb.sv
/*
 * game-pad block testbench
 * table of NES bytes and SNES words, checks source selection,
 * SNES presence and the pressed-button filter on the output pins
 */
`include "pad_cfg.svh"

module pad_tb
    import pad_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS   = 13;
    localparam int TIMEOUT = 20000;    // cycles per nes_latch wait
    localparam int BUSY_TO = 1000;     // cycles per SNES source wait

    logic clk = 1'b0;
    logic rst_n;
    logic nes_data, pmod_data, pmod_clk, pmod_latch;
    logic nes_latch, nes_clk, snes_active;
    logic a, b, select, start, up, down, left, right, x, y, l, r;
    nes_byte_t   pad_byte;             // buttons held on the NES pad
    logic        snes_send;
    snes_frame_t snes_word;
    logic        snes_busy;

    // stimulus table
    nes_byte_t   nes_tab    [NROWS];
    snes_frame_t snes_tab   [NROWS];
    bit          stream_tab [NROWS];   // SNES source sends this row
    string       label_tab  [NROWS];

    integer seed = 11929;
    int     pass_rows = 0;
    int     fail_rows = 0;
    bit     timed_out = 1'b0;

    always #4 clk = ~clk;              // 8 ns

    pad_top dut_i (
        .clk(clk), .rst_n(rst_n), .nes_data(nes_data),
        .pmod_data(pmod_data), .pmod_clk(pmod_clk), .pmod_latch(pmod_latch),
        .nes_latch(nes_latch), .nes_clk(nes_clk),
        .a(a), .b(b), .select(select), .start(start),
        .up(up), .down(down), .left(left), .right(right),
        .x(x), .y(y), .l(l), .r(r), .snes_active(snes_active)
    );

    nes_pad_model nes_pad_i (
        .nes_latch(nes_latch), .nes_clk(nes_clk),
        .pad_byte(pad_byte), .nes_data(nes_data)
    );

    snes_pmod_source snes_src_i (
        .clk(clk), .send(snes_send), .word(snes_word), .busy(snes_busy),
        .pmod_data(pmod_data), .pmod_clk(pmod_clk), .pmod_latch(pmod_latch)
    );

    task automatic set_row(input int i, input nes_byte_t nb, input snes_frame_t sw,
                           input bit st, input string lbl);
        nes_tab[i]    = nb;
        snes_tab[i]   = sw;
        stream_tab[i] = st;
        label_tab[i]  = lbl;
    endtask

    task automatic build_table();
        set_row(0,  8'b1001_0000, '1, 1'b0, "nes a+start");
        set_row(1,  8'h00, '1, 1'b0, "nes none");
        set_row(2,  8'hff, '1, 1'b0, "nes all");
        set_row(3,  8'($random(seed)), '1, 1'b0, "nes random 0");
        set_row(4,  8'($random(seed)), '1, 1'b0, "nes random 1");
        set_row(5,  8'h3c, 12'h800, 1'b1, "snes b");
        set_row(6,  8'($random(seed)), 12'h00c, 1'b1, "snes a+x");
        set_row(7,  8'hff, 12'h082, 1'b1, "snes up+l");
        set_row(8,  8'ha5, 12'h000, 1'b1, "snes nothing pressed");
        set_row(9,  8'($random(seed)), 12'h8c0, 1'b1, "snes three pressed");
        set_row(10, 8'h81, 12'h7ff, 1'b1, "snes eleven pressed");
        set_row(11, 8'($random(seed)), 12'hfff, 1'b1, "snes absent");
        set_row(12, 8'($random(seed)), 12'hfff, 1'b0, "nes after absent");
    endtask

    // pins in SNES frame order, b y sel start u d l r a x l r
    function automatic snes_frame_t sampled_buttons();
        return {b, y, select, start, up, down, left, right, a, x, l, r};
    endfunction

    function automatic int count_pressed(snes_frame_t fr);
        int n;
        n = 0;
        for (int i = 0; i < `PAD_SNES_BITS; i++) begin
            if (fr[i]) n++;
        end
        return n;
    endfunction

    // selection and filter rules, fr is the last frame the adapter sent
    function automatic snes_frame_t expected_buttons(nes_byte_t nb, snes_frame_t fr);
        if (fr == '1) begin
            return {nb[6], 1'b0, nb[5:0], nb[7], 3'b000};  // NES path, x y l r low
        end else if (count_pressed(fr) > `PAD_MAX_PRESSED) begin
            return '0;                                     // implausible frame
        end else begin
            return fr;
        end
    endfunction

    task automatic wait_latch_fall(input string what, output bit ok);
        logic       prev;
        nes_state_t st;
        ok = 1'b0;
        @(negedge clk);
        prev = nes_latch;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (prev && !nes_latch) begin
                ok = 1'b1;
                break;
            end
            prev = nes_latch;
        end
        if (!ok) begin
            st = dut_i.nes_poller_i.state;
            $display("timeout: nes_latch did not fall within %0d cycles in %s, poller in %s",
                     TIMEOUT, what, st.name());
        end
    endtask

    task automatic wait_busy(input logic level, input string what, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < BUSY_TO; n++) begin
            @(negedge clk);
            if (snes_busy === level) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) $display("timeout: SNES source did not %s within %0d cycles", what, BUSY_TO);
    endtask

    task automatic send_snes(input snes_frame_t w, output bit ok);
        @(posedge clk);
        snes_word <= w;
        snes_send <= 1'b1;
        wait_busy(1'b1, "start", ok);
        @(posedge clk);
        snes_send <= 1'b0;
        if (ok) wait_busy(1'b0, "finish", ok);
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        for (int n = 0; n < 6; n++) begin
            @(negedge clk);
            if (n == 3) begin
                @(posedge clk);
                rst_n <= 1'b1;         // five clock edges with reset low
                @(negedge clk);
            end
            // latch rises on the first edge after reset, poll takes ~6600 cycles
            assert (nes_latch === (n >= 4) && nes_clk === 1'b0) else begin
                $display("Fail at %0d ns: nes_latch %b nes_clk %b in reset step %0d",
                         $time, nes_latch, nes_clk, n);
                errs++;
            end
            assert (sampled_buttons() === '0 && snes_active === 1'b0) else begin
                $display("Fail at %0d ns: buttons %03h active %b after reset",
                         $time, sampled_buttons(), snes_active);
                errs++;
            end
        end
        if (errs == 0) pass_rows++;
        else fail_rows++;
        $display("reset: %s", (errs == 0) ? "ok" : "wrong");
    endtask

    task automatic check_row(input int i, input snes_frame_t fr);
        snes_frame_t got;
        snes_frame_t exp;
        bit          exp_active;
        int          errs;
        errs       = 0;
        got        = sampled_buttons();
        exp        = expected_buttons(nes_tab[i], fr);
        exp_active = (fr != '1);
        assert (got === exp) else begin
            $display("Fail at %0d ns: %s buttons %03h, expected %03h",
                     $time, label_tab[i], got, exp);
            errs++;
        end
        assert (snes_active === exp_active) else begin
            $display("Fail at %0d ns: %s snes_active %b, expected %b",
                     $time, label_tab[i], snes_active, exp_active);
            errs++;
        end
        if (errs == 0) pass_rows++;
        else fail_rows++;
        $display("row %0d %s: %s", i, label_tab[i], (errs == 0) ? "ok" : "wrong");
    endtask

    initial begin
        snes_frame_t cur_frame;
        bit          ok;
        rst_n     = 1'b0;
        pad_byte  = '0;
        snes_send = 1'b0;
        snes_word = '1;
        cur_frame = '1;                // capture comes out of reset as no pad
        ok        = 1'b1;
        build_table();
        check_reset();

        for (int i = 0; i < NROWS; i++) begin
            @(posedge clk);
            pad_byte <= nes_tab[i];
            if (stream_tab[i]) begin
                // second copy clears any partial shift from earlier traffic
                for (int k = 0; k < 2 && ok; k++) begin
                    send_snes(snes_tab[i], ok);
                end
                cur_frame = snes_tab[i];
            end
            // first fall starts a poll on the new byte, second ends it
            for (int k = 0; k < 2 && ok; k++) begin
                wait_latch_fall(label_tab[i], ok);
            end
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
            check_row(i, cur_frame);
        end

        $display("%0d rows passed, %0d rows failed", pass_rows, fail_rows);
        if (timed_out || fail_rows != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+design
design/pad_pkg.sv
design/nes_poller.sv
design/snes_pmod_capture.sv
design/snes_frame_decoder.sv
design/pad_top.sv
tb/pad_models.sv
tb/pad_tb.sv

//--- Makefile
# Verilator build and run for the game-pad testbench

SIM  := obj_dir/Vpad_tb
SRCS := $(filter-out +%,$(shell cat list.f)) design/pad_cfg.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module pad_tb -f list.f -o Vpad_tb

# status comes from the pass line in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf obj_dir
